// File: source/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// datapath and register file sizes
`define CPU_XLEN      32    // word and address width
`define CPU_NREGS     32
`define CPU_RA_W      5     // register index width
`define CPU_OPC_W     5     // opcode and alu-op width

// instruction field positions
`define CPU_OPC_HI    31
`define CPU_OPC_LO    27
`define CPU_RD_LO     22
`define CPU_RS_LO     17
`define CPU_RT_LO     12
`define CPU_SHAMT_LO  7
`define CPU_ALUOP_LO  2

// i-type immediate, sign extended on use
`define CPU_IMM_W     17

// j-type target, zero extended
`define CPU_TGT_W     27

`endif

// File: source/cpu_pkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [`CPU_RA_W-1:0] reg_addr_t;

    typedef enum logic [`CPU_OPC_W-1:0] {
        OPC_RTYPE = 5'b00000,
        OPC_J     = 5'b00001,
        OPC_BNE   = 5'b00010,
        OPC_ADDI  = 5'b00101,
        OPC_BLT   = 5'b00110,
        OPC_SW    = 5'b00111,
        OPC_LW    = 5'b01000
    } opcode_e;

    typedef enum logic [`CPU_OPC_W-1:0] {
        ALU_ADD = 5'b00000,
        ALU_SUB = 5'b00001,
        ALU_AND = 5'b00010,
        ALU_OR  = 5'b00011,
        ALU_SLL = 5'b00100,
        ALU_SRA = 5'b00101
    } alu_op_e;

    // source of a decode operand
    typedef enum logic [1:0] {
        BYP_REG,
        BYP_EX,
        BYP_MEM
    } bypass_sel_e;

    // field helpers, shared by every stage
    function automatic opcode_e ir_opcode(word_t ir);
        return opcode_e'(ir[`CPU_OPC_HI:`CPU_OPC_LO]);
    endfunction

    function automatic reg_addr_t ir_rd(word_t ir);
        return ir[`CPU_RD_LO +: `CPU_RA_W];
    endfunction

    function automatic reg_addr_t ir_rs(word_t ir);
        return ir[`CPU_RS_LO +: `CPU_RA_W];
    endfunction

    function automatic reg_addr_t ir_rt(word_t ir);
        return ir[`CPU_RT_LO +: `CPU_RA_W];
    endfunction

    function automatic word_t ir_imm(word_t ir);
        return {{(`CPU_XLEN-`CPU_IMM_W){ir[`CPU_IMM_W-1]}}, ir[`CPU_IMM_W-1:0]};
    endfunction

    // r-type, addi and lw write rd
    function automatic logic writes_reg(opcode_e op);
        return op inside {OPC_RTYPE, OPC_ADDI, OPC_LW};
    endfunction

endpackage

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module alu import cpu_pkg::*; (
    input  word_t                operand_a_i,
    input  word_t                operand_b_i,
    input  alu_op_e              alu_op_i,
    input  logic [`CPU_RA_W-1:0] shamt_i,
    output word_t                result_o,
    output logic                 not_equal_o,
    output logic                 less_than_o
);

    word_t diff;
    logic  ovf;

    assign diff = operand_a_i - operand_b_i;
    // signed overflow of a - b
    assign ovf  = (operand_a_i[`CPU_XLEN-1] != operand_b_i[`CPU_XLEN-1])
               && (diff[`CPU_XLEN-1] != operand_a_i[`CPU_XLEN-1]);

    assign not_equal_o = |diff;
    assign less_than_o = diff[`CPU_XLEN-1] ^ ovf;     // signed compare

    always_comb begin
        case (alu_op_i)
            ALU_ADD: result_o = operand_a_i + operand_b_i;
            ALU_SUB: result_o = diff;
            ALU_AND: result_o = operand_a_i & operand_b_i;
            ALU_OR:  result_o = operand_a_i | operand_b_i;
            ALU_SLL: result_o = operand_a_i << shamt_i;
            ALU_SRA: result_o = word_t'($signed(operand_a_i) >>> shamt_i);
            default: result_o = '0;     // unused op codes
        endcase
    end

endmodule

`default_nettype wire

// File: source/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module regfile import cpu_pkg::*; (
    input  wire logic  clock,
    input  wire logic  rst_n_i,
    input  wire logic  we_i,
    input  reg_addr_t  waddr_i,
    input  word_t      wdata_i,
    input  reg_addr_t  raddr_a_i,
    input  reg_addr_t  raddr_b_i,
    output word_t      rdata_a_o,
    output word_t      rdata_b_o
);

    word_t regs [`CPU_NREGS];
    logic  wr_ok;

    assign wr_ok = we_i && (waddr_i != '0);    // r0 stays zero

    always_ff @(posedge clock) begin
        if (!rst_n_i)
            regs <= '{default: '0};
        else if (wr_ok)
            regs[waddr_i] <= wdata_i;
    end

    // same-cycle write shows through, covers distance-3 deps
    assign rdata_a_o = (wr_ok && (waddr_i == raddr_a_i)) ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (wr_ok && (waddr_i == raddr_b_i)) ? wdata_i : regs[raddr_b_i];

endmodule

`default_nettype wire

// File: source/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
    input  reg_addr_t   src_a_i,
    input  reg_addr_t   src_b_i,
    input  word_t       dx_ir_i,        // insn in execute
    input  word_t       xm_ir_i,        // insn in memory
    output bypass_sel_e byp_a_o,
    output bypass_sel_e byp_b_o,
    output logic        stall_o
);

    reg_addr_t dx_rd, xm_rd;
    logic      dx_wr, xm_wr;
    logic      dx_lw;

    assign dx_rd = ir_rd(dx_ir_i);
    assign xm_rd = ir_rd(xm_ir_i);
    assign dx_lw = (ir_opcode(dx_ir_i) == OPC_LW);

    // r0 writes never forward
    assign dx_wr = writes_reg(ir_opcode(dx_ir_i)) && (dx_rd != '0);
    assign xm_wr = writes_reg(ir_opcode(xm_ir_i)) && (xm_rd != '0);

    // newest producer first but load data is not ready in execute
    function automatic bypass_sel_e pick(reg_addr_t src);
        if (dx_wr && !dx_lw && (src == dx_rd))
            return BYP_EX;
        else if (xm_wr && (src == xm_rd))
            return BYP_MEM;
        else
            return BYP_REG;
    endfunction

    always_comb begin
        byp_a_o = pick(src_a_i);
        byp_b_o = pick(src_b_i);
    end

    // one load-use bubble then BYP_MEM picks up q_dmem
    assign stall_o = dx_lw && (dx_rd != '0) && ((src_a_i == dx_rd) || (src_b_i == dx_rd));

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module fetch_stage import cpu_pkg::*; (
    input  wire logic  clock,
    input  wire logic  rst_n_i,
    input  word_t      q_imem_i,        // instruction at current pc
    input  wire logic  stall_i,
    input  wire logic  branch_taken_i,
    input  word_t      branch_target_i,
    output word_t      address_imem_o,
    output word_t      fd_pc_o,
    output word_t      fd_ir_o
);

    word_t pc_q;
    word_t pc_next;
    word_t jump_target;
    logic  is_j;

    // j is resolved here, straight off the memory
    assign is_j        = (ir_opcode(q_imem_i) == OPC_J);
    assign jump_target = {{(`CPU_XLEN-`CPU_TGT_W){1'b0}}, q_imem_i[`CPU_TGT_W-1:0]};

    // branch over jump over stall over pc+1
    always_comb begin
        if (branch_taken_i)
            pc_next = branch_target_i;
        else if (is_j)
            pc_next = jump_target;
        else if (stall_i)
            pc_next = pc_q;             // hold for load-use
        else
            pc_next = pc_q + 1'b1;
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i)
            pc_q <= '0;
        else
            pc_q <= pc_next;
    end

    assign address_imem_o = pc_q;

    // fetch/decode latch, nop on flush or on the j itself
    always_ff @(posedge clock) begin
        if (!rst_n_i)
            fd_ir_o <= '0;
        else if (branch_taken_i)
            fd_ir_o <= '0;
        else if (!stall_i)
            fd_ir_o <= is_j ? '0 : q_imem_i;    // a stalled decode insn survives a j
    end

    always_ff @(posedge clock) begin
        if (branch_taken_i || !stall_i)
            fd_pc_o <= pc_q;            // only branches look at it
    end

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  wire logic   clock,
    input  wire logic   rst_n_i,
    input  word_t       fd_pc_i,
    input  word_t       fd_ir_i,
    input  wire logic   stall_i,
    input  wire logic   flush_i,
    input  bypass_sel_e byp_a_i,
    input  bypass_sel_e byp_b_i,
    input  word_t       ex_result_i,    // alu result of the execute insn
    input  word_t       mem_fwd_i,      // load data or alu result of the memory insn
    input  word_t       rd_data_a_i,
    input  word_t       rd_data_b_i,
    output reg_addr_t   rd_addr_a_o,
    output reg_addr_t   rd_addr_b_o,
    output reg_addr_t   src_a_o,
    output reg_addr_t   src_b_o,
    output word_t       dx_pc_o,
    output word_t       dx_ir_o,
    output word_t       dx_a_o,
    output word_t       dx_b_o
);

    opcode_e opc;
    logic    b_reads_rd;
    logic    uses_b;
    word_t   a_val, b_val;

    assign opc        = ir_opcode(fd_ir_i);
    assign b_reads_rd = opc inside {OPC_SW, OPC_BNE, OPC_BLT};     // store data, compare operand
    assign uses_b     = b_reads_rd || (opc == OPC_RTYPE);

    // port a always rs
    assign rd_addr_a_o = ir_rs(fd_ir_i);
    assign rd_addr_b_o = b_reads_rd ? ir_rd(fd_ir_i) : ir_rt(fd_ir_i);

    // addi and lw carry immediate bits in rt, keep them out of the hazard check
    assign src_a_o = rd_addr_a_o;
    assign src_b_o = uses_b ? rd_addr_b_o : '0;

    // bypass muxes
    always_comb begin
        unique case (byp_a_i)
            BYP_EX:  a_val = ex_result_i;
            BYP_MEM: a_val = mem_fwd_i;
            default: a_val = rd_data_a_i;
        endcase
        unique case (byp_b_i)
            BYP_EX:  b_val = ex_result_i;
            BYP_MEM: b_val = mem_fwd_i;
            default: b_val = rd_data_b_i;
        endcase
    end

    // decode/execute latch, bubble on stall or flush
    always_ff @(posedge clock) begin
        if (!rst_n_i)
            dx_ir_o <= '0;
        else if (flush_i || stall_i)
            dx_ir_o <= '0;
        else
            dx_ir_o <= fd_ir_i;
    end

    always_ff @(posedge clock) begin
        dx_pc_o <= fd_pc_i;
        dx_a_o  <= a_val;
        dx_b_o  <= b_val;
    end

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module execute_stage import cpu_pkg::*; (
    input  wire logic  clock,
    input  wire logic  rst_n_i,
    input  word_t      dx_pc_i,
    input  word_t      dx_ir_i,
    input  word_t      dx_a_i,          // rs value
    input  word_t      dx_b_i,          // rt, or rd for sw and branches
    output word_t      ex_result_o,
    output logic       branch_taken_o,
    output word_t      branch_target_o,
    output word_t      xm_ir_o,
    output word_t      xm_o_o,
    output word_t      xm_b_o
);

    opcode_e opc;
    logic    use_imm;
    word_t   op_b;
    alu_op_e op_sel;
    logic    cmp_ne, cmp_lt;

    assign opc     = ir_opcode(dx_ir_i);
    assign use_imm = opc inside {OPC_ADDI, OPC_LW, OPC_SW};    // base plus offset
    assign op_b    = use_imm ? ir_imm(dx_ir_i) : dx_b_i;
    assign op_sel  = use_imm ? ALU_ADD : alu_op_e'(dx_ir_i[`CPU_ALUOP_LO +: `CPU_OPC_W]);

    alu u_main_alu (
        .operand_a_i(dx_a_i), .operand_b_i(op_b), .alu_op_i(op_sel),
        .shamt_i(dx_ir_i[`CPU_SHAMT_LO +: `CPU_RA_W]),
        .result_o(ex_result_o), .not_equal_o(), .less_than_o()
    );

    // rd against rs
    alu u_branch_cmp (
        .operand_a_i(dx_b_i), .operand_b_i(dx_a_i), .alu_op_i(ALU_SUB),
        .shamt_i('0),
        .result_o(), .not_equal_o(cmp_ne), .less_than_o(cmp_lt)
    );

    assign branch_taken_o  = ((opc == OPC_BNE) && cmp_ne) || ((opc == OPC_BLT) && cmp_lt);
    assign branch_target_o = dx_pc_i + 1'b1 + ir_imm(dx_ir_i);

    // execute/memory latch, never stalled or flushed
    always_ff @(posedge clock) begin
        if (!rst_n_i)
            xm_ir_o <= '0;
        else
            xm_ir_o <= dx_ir_i;
    end

    always_ff @(posedge clock) begin
        xm_o_o <= ex_result_o;      // alu result or memory address
        xm_b_o <= dx_b_i;           // store data for sw
    end

endmodule

`default_nettype wire

// File: source/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage import cpu_pkg::*; (
    input  wire logic  clock,
    input  wire logic  rst_n_i,
    input  word_t      xm_ir_i,
    input  word_t      xm_o_i,
    input  word_t      xm_b_i,
    input  word_t      q_dmem_i,        // read data for address_dmem_o
    output word_t      address_dmem_o,
    output word_t      data_o,
    output logic       wren_o,
    output word_t      mem_fwd_o,
    output logic       we_o,
    output reg_addr_t  waddr_o,
    output word_t      wdata_o
);

    opcode_e xm_opc;
    word_t   mw_ir;
    word_t   mw_data;

    assign xm_opc = ir_opcode(xm_ir_i);

    // data memory side
    assign address_dmem_o = xm_o_i;
    assign data_o         = xm_b_i;
    assign wren_o         = (xm_opc == OPC_SW);

    // load result if lw, else the alu result
    assign mem_fwd_o = (xm_opc == OPC_LW) ? q_dmem_i : xm_o_i;

    // memory/writeback latch
    always_ff @(posedge clock) begin
        if (!rst_n_i)
            mw_ir <= '0;
        else
            mw_ir <= xm_ir_i;
    end

    always_ff @(posedge clock) begin
        mw_data <= mem_fwd_o;       // already the write-back value
    end

    // write-back for r-type, addi and lw
    assign we_o    = writes_reg(ir_opcode(mw_ir));
    assign waddr_o = ir_rd(mw_ir);
    assign wdata_o = mw_data;

endmodule

`default_nettype wire

// File: source/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
    input  wire logic  clock,
    input  wire logic  rst_n_i,
    // instruction memory, combinational read
    output word_t      address_imem_o,
    input  word_t      q_imem_i,
    // data memory
    output word_t      address_dmem_o,
    output word_t      data_o,
    output logic       wren_o,
    input  word_t      q_dmem_i
);

    // control flow and hazards
    logic        stall;
    logic        branch_taken;
    word_t       branch_target;
    bypass_sel_e byp_a, byp_b;

    // fetch/decode latch
    word_t       fd_pc, fd_ir;

    // register file ports
    reg_addr_t   rd_addr_a, rd_addr_b;
    word_t       rd_data_a, rd_data_b;
    logic        rf_we;
    reg_addr_t   rf_waddr;
    word_t       rf_wdata;

    // decode sources seen by the hazard unit
    reg_addr_t   src_a, src_b;

    // decode/execute latch
    word_t       dx_pc, dx_ir, dx_a, dx_b;

    // execute/memory latch and forward values
    word_t       ex_result;
    word_t       xm_ir, xm_o, xm_b;
    word_t       mem_fwd;

    fetch_stage u_fetch (
        .clock, .rst_n_i, .q_imem_i,
        .stall_i(stall), .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .address_imem_o, .fd_pc_o(fd_pc), .fd_ir_o(fd_ir)
    );

    decode_stage u_decode (
        .clock, .rst_n_i, .fd_pc_i(fd_pc), .fd_ir_i(fd_ir),
        .stall_i(stall), .flush_i(branch_taken),    // taken branch kills decode
        .byp_a_i(byp_a), .byp_b_i(byp_b), .ex_result_i(ex_result), .mem_fwd_i(mem_fwd),
        .rd_data_a_i(rd_data_a), .rd_data_b_i(rd_data_b),
        .rd_addr_a_o(rd_addr_a), .rd_addr_b_o(rd_addr_b),
        .src_a_o(src_a), .src_b_o(src_b),
        .dx_pc_o(dx_pc), .dx_ir_o(dx_ir), .dx_a_o(dx_a), .dx_b_o(dx_b)
    );

    hazard_unit u_hazard (
        .src_a_i(src_a), .src_b_i(src_b), .dx_ir_i(dx_ir), .xm_ir_i(xm_ir),
        .byp_a_o(byp_a), .byp_b_o(byp_b), .stall_o(stall)
    );

    regfile u_regfile (
        .clock, .rst_n_i, .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
        .raddr_a_i(rd_addr_a), .raddr_b_i(rd_addr_b),
        .rdata_a_o(rd_data_a), .rdata_b_o(rd_data_b)
    );

    execute_stage u_execute (
        .clock, .rst_n_i, .dx_pc_i(dx_pc), .dx_ir_i(dx_ir), .dx_a_i(dx_a), .dx_b_i(dx_b),
        .ex_result_o(ex_result), .branch_taken_o(branch_taken),
        .branch_target_o(branch_target),
        .xm_ir_o(xm_ir), .xm_o_o(xm_o), .xm_b_o(xm_b)
    );

    mem_wb_stage u_mem_wb (
        .clock, .rst_n_i, .xm_ir_i(xm_ir), .xm_o_i(xm_o), .xm_b_i(xm_b), .q_dmem_i,
        .address_dmem_o, .data_o, .wren_o, .mem_fwd_o(mem_fwd),
        .we_o(rf_we), .waddr_o(rf_waddr), .wdata_o(rf_wdata)
    );

endmodule

`default_nettype wire

// File: test/cpu_core_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_chk import cpu_pkg::*; (
    input  wire logic  clock,
    input  wire logic  rst_n_i,
    input  wire logic  wren_i,
    input  word_t      imem_addr_i,
    input  word_t      dmem_addr_i,
    input  word_t      dmem_data_i
);

    logic in_rst_q = 1'b0;          // reset seen at the previous edge
    int   n_fail = 0;               // failed assertions so far

    always @(posedge clock) begin
        in_rst_q <= !rst_n_i;
    end

    // latches already cleared by an earlier reset edge
    wren_low_in_reset: assert property (@(posedge clock)
        (!rst_n_i && in_rst_q) |-> !wren_i)
        else begin
            $error("wren_o high while reset is held");
            n_fail++;
        end

    imem_zero_after_reset: assert property (@(posedge clock)
        (rst_n_i && in_rst_q) |-> (imem_addr_i == '0))
        else begin
            $error("fetch address not zero in the first cycle after reset");
            n_fail++;
        end

    store_known: assert property (@(posedge clock)
        (rst_n_i && wren_i) |-> !$isunknown({dmem_addr_i, dmem_data_i}))
        else begin
            $error("store with unknown address or data");
            n_fail++;
        end

endmodule

`default_nettype wire

// File: test/cpu_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb import cpu_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 10;
    localparam int N_PROGS    = 40;
    localparam int BODY_LEN   = 40;
    localparam int PROG_LEN   = BODY_LEN + 8;   // seven dump stores plus halt loop

    logic  clock;
    logic  rst_n_i = 1'b0;
    word_t q_imem_i = '0;
    word_t q_dmem_i = '0;
    word_t address_imem_o, address_dmem_o, data_o;
    logic  wren_o;

    word_t prog [256];
    word_t dmem [256];              // environment data memory
    word_t model_mem [256];
    word_t model_reg [32];
    word_t exp_addr [$];            // expected stores of all programs in order
    word_t exp_data [$];
    int    n_seen = 0;
    int    n_checked = 0;
    int    n_errors = 0;
    int    prog_idx;

    cpu_core uut (
        .clock, .rst_n_i, .address_imem_o, .q_imem_i,
        .address_dmem_o, .data_o, .wren_o, .q_dmem_i
    );

    bind cpu_core cpu_core_chk u_chk (
        .clock(clock), .rst_n_i(rst_n_i), .wren_i(wren_o), .imem_addr_i(address_imem_o),
        .dmem_addr_i(address_dmem_o), .dmem_data_i(data_o)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // every byte of the address shows up in the word
    function automatic word_t fill_word(int a);
        return {a[7:0], ~a[7:0], a[7:0] ^ 8'h5a, a[7:0] * 8'd37};
    endfunction

    function automatic word_t enc_r(int fn, int rd, int rs, int rt, int sh);
        return {5'b00000, rd[4:0], rs[4:0], rt[4:0], sh[4:0], fn[4:0], 2'b00};
    endfunction

    function automatic word_t enc_i(opcode_e opc, int rd, int rs, int imm);
        return {opc, rd[4:0], rs[4:0], imm[16:0]};
    endfunction

    function automatic word_t enc_j(int tgt);
        return {OPC_J, tgt[26:0]};
    endfunction

    function automatic int rnd_rd();
        return 1 + ($urandom % 7);  // r1..r7 only so hazards are dense
    endfunction

    function automatic int rnd_rs();
        return $urandom % 8;
    endfunction

    task automatic gen_program();
        int i;
        int kind;
        int t;
        for (i = 0; i < 256; i++)
            prog[i] = '0;           // nop beyond the program
        for (i = 0; i < BODY_LEN; i++) begin
            kind = $urandom % 16;
            t = i + 1 + ($urandom % 4);
            if (t > BODY_LEN)
                t = BODY_LEN;       // never skip into the dump
            case (kind)
                6, 7:    prog[i] = enc_i(OPC_ADDI, rnd_rd(), rnd_rs(), $urandom);
                8, 9:    prog[i] = enc_i(OPC_LW, rnd_rd(), 0, $urandom % 256);
                10, 11:  prog[i] = enc_i(OPC_SW, rnd_rs(), 0, $urandom % 256);
                12:      prog[i] = enc_i(OPC_BNE, rnd_rs(), rnd_rs(), t - i - 1);
                13:      prog[i] = enc_i(OPC_BLT, rnd_rs(), rnd_rs(), t - i - 1);
                14:      prog[i] = enc_j(t);
                default: prog[i] = enc_r($urandom % 6, rnd_rd(), rnd_rs(), rnd_rs(),
                                         $urandom % 32);
            endcase
        end
        for (i = 1; i < 8; i++)
            prog[BODY_LEN + i - 1] = enc_i(OPC_SW, i, 0, 248 + i);   // register dump
        prog[PROG_LEN - 1] = enc_j(PROG_LEN - 1);                    // halt
    endtask

    // architectural interpreter that appends the stores it makes
    task automatic run_model();
        word_t ir, pc, rs_v, rt_v, rd_v, imm, res, addr;
        logic signed [31:0] sa;
        logic wr;
        int i;
        int steps;
        for (i = 0; i < 32; i++)
            model_reg[i] = '0;
        for (i = 0; i < 256; i++)
            model_mem[i] = fill_word(i);
        pc = '0;
        steps = 0;
        while (pc != PROG_LEN - 1 && steps < 4 * PROG_LEN) begin
            ir   = prog[pc[7:0]];
            rs_v = model_reg[ir[21:17]];
            rt_v = model_reg[ir[16:12]];
            rd_v = model_reg[ir[26:22]];    // store data or branch operand
            imm  = {{15{ir[16]}}, ir[16:0]};
            addr = rs_v + imm;
            wr   = 1'b0;
            res  = '0;
            pc   = pc + 1;
            case (ir[31:27])
                OPC_RTYPE: begin
                    wr = 1'b1;
                    sa = rs_v;
                    case (ir[6:2])
                        5'd0:    res = rs_v + rt_v;
                        5'd1:    res = rs_v - rt_v;
                        5'd2:    res = rs_v & rt_v;
                        5'd3:    res = rs_v | rt_v;
                        5'd4:    res = rs_v << ir[11:7];
                        default: res = sa >>> ir[11:7];
                    endcase
                end
                OPC_ADDI: begin
                    wr  = 1'b1;
                    res = addr;
                end
                OPC_LW: begin
                    wr  = 1'b1;
                    res = model_mem[addr[7:0]];
                end
                OPC_SW: begin
                    model_mem[addr[7:0]] = rd_v;
                    exp_addr.push_back(addr);
                    exp_data.push_back(rd_v);
                end
                OPC_BNE: if (rd_v != rs_v) pc = pc + imm;
                OPC_BLT: if ($signed(rd_v) < $signed(rs_v)) pc = pc + imm;
                OPC_J:   pc = {5'b00000, ir[26:0]};
                default: ;
            endcase
            if (wr && ir[26:22] != 5'd0)
                model_reg[ir[26:22]] = res;
            steps++;
        end
    endtask

    // memories answer on the falling edge where stores are checked too
    always @(negedge clock) begin
        q_imem_i = prog[address_imem_o[7:0]];
        q_dmem_i = dmem[address_dmem_o[7:0]];
        if (rst_n_i && wren_o === 1'b1) begin
            if (n_seen >= exp_addr.size()) begin
                n_errors++;
                $display("error: program %0d made a store to %h that the model never makes",
                         prog_idx, address_dmem_o);
            end else begin
                if (address_dmem_o !== exp_addr[n_seen]) begin
                    n_errors++;
                    $display("error prog %0d store %0d address: expected %h, actual %h",
                             prog_idx, n_seen, exp_addr[n_seen], address_dmem_o);
                end
                if (data_o !== exp_data[n_seen]) begin
                    n_errors++;
                    $display("error prog %0d store %0d data: expected %h, actual %h",
                             prog_idx, n_seen, exp_data[n_seen], data_o);
                end
                n_checked++;
            end
            n_seen++;
        end
    end

    always @(posedge clock) begin
        if (!rst_n_i) begin
            for (int a = 0; a < 256; a++)
                dmem[a] <= fill_word(a);    // fresh contents each program
        end else if (wren_o) begin
            dmem[address_dmem_o[7:0]] <= data_o;
        end
    end

    initial begin
        void'($urandom(71));
        for (prog_idx = 0; prog_idx < N_PROGS; prog_idx++) begin
            @(negedge clock);
            rst_n_i = 1'b0;
            gen_program();
            run_model();
            repeat (RST_CYCLES) @(negedge clock);
            rst_n_i = 1'b1;
            while (n_seen < exp_addr.size())
                @(negedge clock);           // dump stores end each program
            repeat (4) @(negedge clock);    // room for a stray store
        end
        $display("stores checked %0d, errors %0d, assertion failures %0d",
                 n_checked, n_errors, uut.u_chk.n_fail);
        if (n_errors == 0 && uut.u_chk.n_fail == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // 4 cycles per insn plus reset and idle time for every program
    initial begin
        #(N_PROGS * (PROG_LEN * 4 + RST_CYCLES + 8) * CLK_PERIOD);
        $display("timeout: the core stopped before making all expected stores");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
source/cpu_pkg.sv
source/alu.sv
source/regfile.sv
source/hazard_unit.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/cpu_core.sv
test/cpu_core_chk.sv
test/cpu_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the log
verilator --binary --timing --assert -f vlog.f --top-module cpu_core_tb -o cpu_core_sim \
    && ./obj_dir/cpu_core_sim | tee sim.log \
    && grep -q "ALL CHECKS PASSED" sim.log \
    || { echo "simulation did not pass"; exit 1; }
